// ==== all.f ====
hw/rv_pkg.sv
hw/register_file.sv
hw/alu.sv
hw/immediate_extender.sv
hw/dataflow.sv
hw/control_unit.sv
hw/rv_core.sv
tests/tb_clock.sv
tests/rv_core_props.sv
tests/rv_core_tb.sv

// ==== hw/alu.sv ====
// ================================================
// alu
// Combinational RV32I ALU. Operation select uses
// funct3 encoding. Flags always come from a - b
// so branches resolve without a separate compare
// ================================================

`timescale 1ns/1ps

module alu import rv_pkg::*; (
  input  word_t    a,
  input  word_t    b,
  input  alu_sel_t alu_sel,
  input  logic     sub,
  input  logic     arithmetic,
  output word_t    y,
  output flags_t   flags
);

  logic [32:0] diff_ext;
  word_t       diff;
  word_t       add_sub;
  logic [4:0]  shamt;
  logic        less_signed;

  // Subtraction as a + ~b + 1, carry set means a >= b unsigned
  assign diff_ext = {1'b0, a} + {1'b0, ~b} + 33'd1;
  assign diff     = diff_ext[31:0];

  assign flags.zero      = (diff == '0);
  assign flags.negative  = diff[31];
  assign flags.carry_out = diff_ext[32];
  assign flags.overflow  = (a[31] ^ b[31]) & (diff[31] ^ a[31]);

  assign less_signed = flags.negative ^ flags.overflow;
  assign add_sub     = sub ? diff : (a + b);
  assign shamt       = b[4:0];

  always_comb begin
    case (alu_sel)
      ALU_ADD:  y = add_sub;
      ALU_SLL:  y = a << shamt;
      ALU_SLT:  y = {31'b0, less_signed};
      ALU_SLTU: y = {31'b0, ~flags.carry_out};
      ALU_XOR:  y = a ^ b;
      ALU_SR: begin
        if (arithmetic) begin
          y = word_t'($signed(a) >>> shamt);
        end else begin
          y = a >> shamt;
        end
      end
      ALU_OR:   y = a | b;
      ALU_AND:  y = a & b;
      default:  y = add_sub;
    endcase
  end

endmodule

// ==== hw/control_unit.sv ====
// ================================================
// control_unit
// Multicycle FSM stepping each instruction through
// fetch, decode, execute, memory and write-back.
// Resolves branches from the ALU flags
// ================================================

`timescale 1ns/1ps

module control_unit import rv_pkg::*; (
  input  logic    clock,
  input  logic    rst_n,
  input  decode_t decode,
  input  flags_t  flags,
  output ctrl_t   ctrl,
  output logic    mem_wr_en,
  output logic    halted
);

  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  cu_state_e state;
  cu_state_e next_state;
  logic      branch_taken;
  logic      signed_less;
  logic      known_op;

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      state <= FETCH;
    end else begin
      state <= next_state;
    end
  end

  assign signed_less = flags.negative ^ flags.overflow;

  // Branch outcome from the a - b flags
  always_comb begin
    case (decode.funct3)
      F3_BEQ:  branch_taken = flags.zero;
      F3_BNE:  branch_taken = ~flags.zero;
      F3_BLT:  branch_taken = signed_less;
      F3_BGE:  branch_taken = ~signed_less;
      F3_BLTU: branch_taken = ~flags.carry_out;
      F3_BGEU: branch_taken = flags.carry_out;
      default: branch_taken = 1'b0;
    endcase
  end

  assign known_op = (decode.opcode inside {OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR,
                                           OPC_BRANCH, OPC_LOAD, OPC_STORE,
                                           OPC_OP_IMM, OPC_OP});

  always_comb begin
    next_state = state;
    case (state)
      FETCH: next_state = DECODE;
      // ECALL and anything not decoded stop the core
      DECODE: next_state = known_op ? EXECUTE : HALT;
      EXECUTE: begin
        if (decode.opcode == OPC_BRANCH) begin
          next_state = FETCH;
        end else if (decode.opcode inside {OPC_LOAD, OPC_STORE}) begin
          next_state = MEMORY;
        end else begin
          next_state = WRITEBACK;
        end
      end
      MEMORY: next_state = (decode.opcode == OPC_LOAD) ? WRITEBACK : FETCH;
      WRITEBACK: next_state = FETCH;
      HALT: next_state = HALT;
      default: next_state = FETCH;
    endcase
  end

  always_comb begin
    ctrl         = '0;
    ctrl.alu_sel = ALU_ADD;
    mem_wr_en    = 1'b0;

    // ALU setup depends only on the opcode and holds across states
    case (decode.opcode)
      OPC_OP: begin
        ctrl.alu_sel    = decode.funct3;
        ctrl.sub        = (decode.funct3 == ALU_ADD) && decode.funct7[5];
        ctrl.arithmetic = decode.funct7[5];
      end
      OPC_OP_IMM: begin
        ctrl.alub_src   = 1'b1;
        ctrl.alu_sel    = decode.funct3;
        // Only srai looks at funct7
        ctrl.arithmetic = (decode.funct3 == ALU_SR) && decode.funct7[5];
      end
      OPC_LUI, OPC_LOAD, OPC_STORE: ctrl.alub_src = 1'b1;
      OPC_AUIPC: begin
        ctrl.alua_src = 1'b1;
        ctrl.alub_src = 1'b1;
      end
      OPC_JALR: ctrl.alupc_src = 1'b1;
      default: ;
    endcase

    case (state)
      FETCH: ctrl.ir_en = 1'b1;
      EXECUTE: begin
        if (decode.opcode == OPC_BRANCH) begin
          ctrl.pc_src = branch_taken;
          ctrl.pc_en  = 1'b1;
        end
      end
      MEMORY: begin
        ctrl.mem_addr_src = 1'b1;
        if (decode.opcode == OPC_STORE) begin
          mem_wr_en   = 1'b1;
          ctrl.pc_en  = 1'b1;
        end
      end
      WRITEBACK: begin
        ctrl.wr_reg_en = 1'b1;
        ctrl.pc_en     = 1'b1;
        if (decode.opcode == OPC_LOAD) begin
          // Address must stay on the ALU while load data is written
          ctrl.mem_addr_src = 1'b1;
          ctrl.wr_reg_src   = WB_MEM;
        end else if (decode.opcode inside {OPC_JAL, OPC_JALR}) begin
          ctrl.wr_reg_src = WB_PC4;
          ctrl.pc_src     = 1'b1;
        end else begin
          ctrl.wr_reg_src = WB_ALU;
        end
      end
      default: ;
    endcase
  end

  assign halted = (state == HALT);

endmodule

// ==== hw/dataflow.sv ====
// ================================================
// dataflow
// Shared datapath of the multicycle core. Holds PC
// and IR, the register file, ALU, immediate unit,
// operand and write-back muxes and the PC adders
// ================================================

`timescale 1ns/1ps

module dataflow import rv_pkg::*; #(
  parameter word_t RESET_PC = 32'h0000_0000
) (
  input  logic    clock,
  input  logic    rst_n,
  input  ctrl_t   ctrl,
  input  word_t   mem_rd_data,
  output word_t   mem_addr,
  output word_t   mem_wr_data,
  output decode_t decode,
  output flags_t  flags
);

  word_t     pc;
  word_t     ir;
  word_t     next_pc;
  word_t     pc_plus_4;
  word_t     jump_base;
  word_t     jump_sum;
  word_t     jump_target;
  word_t     immediate;
  word_t     rs1_data;
  word_t     rs2_data;
  word_t     rd_data;
  word_t     alu_a;
  word_t     alu_b;
  word_t     alu_y;
  reg_addr_t rs1_addr;

  // PC moves only on the last cycle of an instruction
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      pc <= RESET_PC;
    end else if (ctrl.pc_en) begin
      pc <= next_pc;
    end
  end

  // Instruction register, loaded during fetch
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      ir <= '0;
    end else if (ctrl.ir_en) begin
      ir <= mem_rd_data;
    end
  end

  // LUI reads x0 so the ALU produces 0 + imm
  assign rs1_addr = (ir[6:0] == OPC_LUI) ? '0 : ir[19:15];

  register_file u_register_file (
    .clock    (clock),
    .rst_n    (rst_n),
    .wr_en    (ctrl.wr_reg_en),
    .rs1_addr (rs1_addr),
    .rs2_addr (ir[24:20]),
    .rd_addr  (ir[11:7]),
    .rd_data  (rd_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  immediate_extender u_immediate_extender (
    .instruction (ir),
    .immediate   (immediate)
  );

  assign alu_a = ctrl.alua_src ? pc : rs1_data;
  assign alu_b = ctrl.alub_src ? immediate : rs2_data;

  alu u_alu (
    .a          (alu_a),
    .b          (alu_b),
    .alu_sel    (ctrl.alu_sel),
    .sub        (ctrl.sub),
    .arithmetic (ctrl.arithmetic),
    .y          (alu_y),
    .flags      (flags)
  );

  // Sequential PC and jump/branch target
  assign pc_plus_4   = pc + 32'd4;
  assign jump_base   = ctrl.alupc_src ? rs1_data : pc;
  assign jump_sum    = jump_base + immediate;
  assign jump_target = {jump_sum[31:1], 1'b0};
  assign next_pc     = ctrl.pc_src ? jump_target : pc_plus_4;

  always_comb begin
    case (ctrl.wr_reg_src)
      WB_MEM:  rd_data = mem_rd_data;
      WB_PC4:  rd_data = pc_plus_4;
      default: rd_data = alu_y;
    endcase
  end

  assign mem_addr    = ctrl.mem_addr_src ? alu_y : pc;
  assign mem_wr_data = rs2_data;

  assign decode.opcode = ir[6:0];
  assign decode.funct3 = ir[14:12];
  assign decode.funct7 = ir[31:25];

endmodule

// ==== hw/immediate_extender.sv ====
// ================================================
// immediate_extender
// Decodes the instruction format from the opcode
// and builds the sign-extended immediate for the
// I, S, B, U and J formats
// ================================================

`timescale 1ns/1ps

module immediate_extender import rv_pkg::*; (
  input  word_t instruction,
  output word_t immediate
);

  logic [6:0] opcode;
  logic       sign;

  assign opcode = instruction[6:0];
  assign sign   = instruction[31];

  always_comb begin
    case (opcode)
      // I format
      OPC_OP_IMM, OPC_LOAD, OPC_JALR, OPC_SYSTEM: begin
        immediate = {{20{sign}}, instruction[31:20]};
      end
      OPC_STORE: begin
        immediate = {{20{sign}}, instruction[31:25], instruction[11:7]};
      end
      // B format, byte offset so bit 0 is zero
      OPC_BRANCH: begin
        immediate = {{19{sign}}, sign, instruction[7], instruction[30:25],
                     instruction[11:8], 1'b0};
      end
      OPC_LUI, OPC_AUIPC: begin
        immediate = {instruction[31:12], 12'b0};
      end
      OPC_JAL: begin
        immediate = {{11{sign}}, sign, instruction[19:12], instruction[20],
                     instruction[30:21], 1'b0};
      end
      // R type and unknown opcodes carry no immediate
      default: begin
        immediate = '0;
      end
    endcase
  end

endmodule

// ==== hw/register_file.sv ====
// ================================================
// register_file
// 32 x 32-bit integer registers with two
// combinational read ports and one write port.
// x0 always reads as zero
// ================================================

`timescale 1ns/1ps

module register_file import rv_pkg::*; (
  input  logic      clock,
  input  logic      rst_n,
  input  logic      wr_en,
  input  reg_addr_t rs1_addr,
  input  reg_addr_t rs2_addr,
  input  reg_addr_t rd_addr,
  input  word_t     rd_data,
  output word_t     rs1_data,
  output word_t     rs2_data
);

  word_t regs [32];

  // Synchronous clear of the whole bank on reset
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && (rd_addr != '0)) begin
      regs[rd_addr] <= rd_data;
    end
  end

  // Writes to x0 are dropped above, reads of x0 forced here too
  always_comb begin
    if (rs1_addr == '0) begin
      rs1_data = '0;
    end else begin
      rs1_data = regs[rs1_addr];
    end
    if (rs2_addr == '0) begin
      rs2_data = '0;
    end else begin
      rs2_data = regs[rs2_addr];
    end
  end

endmodule

// ==== hw/rv_core.sv ====
// ================================================
// rv_core
// Multicycle RV32I core top. Joins the control FSM
// to the datapath and exposes one word-wide memory
// port with a combinational read
// ================================================

`timescale 1ns/1ps

module rv_core import rv_pkg::*; #(
  parameter word_t RESET_PC = 32'h0000_0000
) (
  input  logic  clock,
  input  logic  rst_n,
  output word_t mem_addr,
  output word_t mem_wr_data,
  output logic  mem_wr_en,
  input  word_t mem_rd_data,
  output logic  halted
);

  ctrl_t   ctrl;
  decode_t decode;
  flags_t  flags;

  control_unit u_control_unit (
    .clock     (clock),
    .rst_n     (rst_n),
    .decode    (decode),
    .flags     (flags),
    .ctrl      (ctrl),
    .mem_wr_en (mem_wr_en),
    .halted    (halted)
  );

  dataflow #(
    .RESET_PC (RESET_PC)
  ) u_dataflow (
    .clock       (clock),
    .rst_n       (rst_n),
    .ctrl        (ctrl),
    .mem_rd_data (mem_rd_data),
    .mem_addr    (mem_addr),
    .mem_wr_data (mem_wr_data),
    .decode      (decode),
    .flags       (flags)
  );

endmodule

// ==== hw/rv_pkg.sv ====
// ================================================
// rv_pkg
// Shared types for the multicycle RV32I core:
// word widths, datapath controls, decode fields,
// ALU flags and the control FSM states
// ================================================

package rv_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [2:0]  alu_sel_t;
  typedef logic [1:0]  wb_sel_t;

  // ALU operation codes follow funct3
  localparam alu_sel_t ALU_ADD  = 3'b000;
  localparam alu_sel_t ALU_SLL  = 3'b001;
  localparam alu_sel_t ALU_SLT  = 3'b010;
  localparam alu_sel_t ALU_SLTU = 3'b011;
  localparam alu_sel_t ALU_XOR  = 3'b100;
  localparam alu_sel_t ALU_SR   = 3'b101;
  localparam alu_sel_t ALU_OR   = 3'b110;
  localparam alu_sel_t ALU_AND  = 3'b111;

  // Write-back sources
  localparam wb_sel_t WB_ALU = 2'b00;
  localparam wb_sel_t WB_MEM = 2'b10;
  localparam wb_sel_t WB_PC4 = 2'b11;

  // Major opcodes
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  typedef struct packed {
    logic     alua_src;
    logic     alub_src;
    alu_sel_t alu_sel;
    logic     sub;
    logic     arithmetic;
    logic     alupc_src;
    logic     pc_src;
    logic     pc_en;
    wb_sel_t  wr_reg_src;
    logic     wr_reg_en;
    logic     ir_en;
    logic     mem_addr_src;
  } ctrl_t;

  typedef struct packed {
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
  } decode_t;

  typedef struct packed {
    logic zero;
    logic negative;
    logic carry_out;
    logic overflow;
  } flags_t;

  typedef enum logic [2:0] {
    FETCH,
    DECODE,
    EXECUTE,
    MEMORY,
    WRITEBACK,
    HALT
  } cu_state_e;

endpackage

// ==== run.sh ====
#!/bin/sh
# Build and run the rv_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f all.f --top-module rv_core_tb -o rv_core_sim; then
  echo "Verilator build failed"
  exit 1
fi

if ! ./obj_dir/rv_core_sim; then
  echo "Simulation failed"
  exit 1
fi

exit 0

// ==== tests/rv_core_props.sv ====
// ==================================================
// rv_core_props
// Concurrent checks on the core's memory port and
// halt output, bound into every rv_core instance
// ==================================================

`timescale 1ns/1ps

module rv_core_props import rv_pkg::*; (
  input logic  clock,
  input logic  rst_n,
  input word_t mem_addr,
  input logic  mem_wr_en,
  input logic  halted
);

  // No stores once the core has stopped
  no_write_when_halted: assert property (@(posedge clock) disable iff (!rst_n)
    !(mem_wr_en && halted))
    else $error("memory write while halted");

  // Word-only stores
  aligned_write: assert property (@(posedge clock) disable iff (!rst_n)
    mem_wr_en |-> (mem_addr[1:0] == 2'b00))
    else $error("unaligned memory write address %h", mem_addr);

  halted_low_after_reset: assert property (@(posedge clock)
    !rst_n |=> !halted)
    else $error("halted high in the cycle after reset");

endmodule

bind rv_core rv_core_props u_props (.*);

// ==== tests/rv_core_tb.sv ====
// ==================================================
// rv_core_tb
// Directed tests for the multicycle RV32I core:
// memory model, program assembly, result checks
// ==================================================

`timescale 1ns/1ps

module rv_core_tb import rv_pkg::*;;

  localparam word_t RESET_PC  = 32'h0000_0040;
  localparam word_t DATA_BASE = 32'h0000_0800;
  localparam word_t LOAD_BASE = 32'h0000_0A00;
  localparam int    PERIOD_NS = 100;
  localparam int    MAX_PROG_CYCLES = 1000;
  localparam int    NUM_TESTS = 6;
  localparam int    HALT_MARGIN = 10;
  localparam int    WATCHDOG_NS = NUM_TESTS * (MAX_PROG_CYCLES + 40) * PERIOD_NS;

  localparam logic [6:0] OP_LUI = 7'b0110111;
  localparam logic [6:0] OP_AUIPC = 7'b0010111;
  localparam logic [6:0] OP_IMM = 7'b0010011;
  localparam logic [6:0] OP_REG = 7'b0110011;

  logic  clock;
  logic  rst_n;
  logic  load_image;
  word_t mem_addr;
  word_t mem_wr_data;
  logic  mem_wr_en;
  word_t mem_rd_data;
  logic  halted;

  word_t mem [1024];
  word_t image [1024];
  word_t exp_vals [$];
  word_t emit_pc;
  word_t rng;
  int    budget;

  tb_clock #(.PERIOD_NS(PERIOD_NS)) u_clock (.clock(clock));

  rv_core #(.RESET_PC(RESET_PC)) u_dut (
    .clock       (clock),
    .rst_n       (rst_n),
    .mem_addr    (mem_addr),
    .mem_wr_data (mem_wr_data),
    .mem_wr_en   (mem_wr_en),
    .mem_rd_data (mem_rd_data),
    .halted      (halted)
  );

  // Memory model, image copied in during reset
  assign mem_rd_data = mem[mem_addr[11:2]];

  always @(posedge clock) begin
    if (load_image) begin
      for (int i = 0; i < 1024; i++) begin
        mem[i] <= image[i];
      end
    end else if (mem_wr_en) begin
      mem[mem_addr[11:2]] <= mem_wr_data;
    end
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic check(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
      abort_run("value mismatch");
    end
  endtask

  function automatic word_t next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic word_t fill_word(input int idx);
    return 32'hC0DE_0000 | word_t'(idx);
  endfunction

  // Instruction encoders
  function automatic word_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                  input logic [4:0] rs1, input logic [2:0] f3,
                                  input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OP_REG};
  endfunction

  function automatic word_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                  input logic [2:0] f3, input logic [4:0] rd,
                                  input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                  input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic word_t enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                  input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic word_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  task automatic emit(input word_t instr, input int cycles);
    image[emit_pc[11:2]] = instr;
    emit_pc = emit_pc + 32'd4;
    budget = budget + cycles;
  endtask

  task automatic begin_program();
    for (int i = 0; i < 1024; i++) begin
      image[i] = fill_word(i);
    end
    exp_vals.delete();
    emit_pc = RESET_PC;
    budget = 0;
  endtask

  // Two instructions whatever the value
  task automatic load_const(input logic [4:0] rd, input word_t value);
    word_t hi;
    hi = value + 32'h800;
    emit({hi[31:12], rd, OP_LUI}, 4);
    emit(enc_i(value[11:0], rd, 3'b000, rd, OP_IMM), 4);
  endtask

  // Reserves a result slot at DATA_BASE and stores rs into it
  task automatic store_expect(input logic [4:0] rs, input word_t value);
    word_t off;
    off = word_t'(exp_vals.size() * 4);
    exp_vals.push_back(value);
    emit(enc_s(off[11:0], rs, 5'd10), 4);
  endtask

  // Slot the core must never write
  task automatic store_forbidden(input logic [4:0] rs);
    store_expect(rs, fill_word(int'((DATA_BASE >> 2) + exp_vals.size())));
  endtask

  task automatic apply_reset();
    @(negedge clock);
    rst_n = 1'b0;
    load_image = 1'b1;
    @(negedge clock);
    load_image = 1'b0;
    repeat (7) @(negedge clock);
    rst_n = 1'b1;
  endtask

  task automatic wait_halt();
    int n;
    n = 0;
    while (!halted) begin
      @(negedge clock);
      n++;
      if (n > budget + HALT_MARGIN) begin
        abort_run($sformatf("core did not halt within %0d cycles", budget + HALT_MARGIN));
      end
    end
  endtask

  task automatic verify_slots();
    word_t addr;
    foreach (exp_vals[i]) begin
      addr = DATA_BASE + word_t'(i * 4);
      check($sformatf("mem[0x%0h]", addr), mem[addr[11:2]], exp_vals[i]);
    end
  endtask

  task automatic run_program();
    emit(32'h0000_0073, 2);
    apply_reset();
    wait_halt();
    verify_slots();
  endtask

  task automatic test_reset_fetch();
    begin_program();
    emit(enc_i(12'd5, 5'd0, 3'b000, 5'd1, OP_IMM), 4);
    emit(enc_i(12'd7, 5'd1, 3'b000, 5'd1, OP_IMM), 4);
    load_const(5'd10, DATA_BASE);
    store_expect(5'd1, 32'd12);
    emit(32'h0000_0073, 2);
    apply_reset();
    check("mem_addr", mem_addr, RESET_PC);
    check("mem_wr_en", word_t'(mem_wr_en), 32'd0);
    check("halted", word_t'(halted), 32'd0);
    repeat (4) @(negedge clock);
    check("mem_addr", mem_addr, RESET_PC + 32'd4);
    wait_halt();
    verify_slots();
  endtask

  task automatic alu_r(input logic [6:0] f7, input logic [2:0] f3, input word_t exp);
    emit(enc_r(f7, 5'd2, 5'd1, f3, 5'd3), 4);
    store_expect(5'd3, exp);
  endtask

  task automatic alu_i(input logic [11:0] imm, input logic [2:0] f3, input word_t exp);
    emit(enc_i(imm, 5'd1, f3, 5'd3, OP_IMM), 4);
    store_expect(5'd3, exp);
  endtask

  task automatic test_alu();
    word_t a;
    word_t b;
    word_t si;
    logic [11:0] imm;
    logic [4:0] sh;
    begin_program();
    load_const(5'd10, DATA_BASE);
    for (int round = 0; round < 2; round++) begin
      a = next_rand();
      b = next_rand();
      imm = 12'(next_rand());
      sh = b[4:0];
      si = {{20{imm[11]}}, imm};
      load_const(5'd1, a);
      load_const(5'd2, b);
      alu_r(7'h00, 3'b000, a + b);
      alu_r(7'h20, 3'b000, a - b);
      alu_r(7'h00, 3'b001, a << sh);
      alu_r(7'h00, 3'b010, word_t'($signed(a) < $signed(b)));
      alu_r(7'h00, 3'b011, word_t'(a < b));
      alu_r(7'h00, 3'b100, a ^ b);
      alu_r(7'h00, 3'b101, a >> sh);
      alu_r(7'h20, 3'b101, word_t'($signed(a) >>> sh));
      alu_r(7'h00, 3'b110, a | b);
      alu_r(7'h00, 3'b111, a & b);
      alu_i(imm, 3'b000, a + si);
      alu_i(imm, 3'b010, word_t'($signed(a) < $signed(si)));
      alu_i(imm, 3'b011, word_t'(a < si));
      alu_i(imm, 3'b100, a ^ si);
      alu_i(imm, 3'b110, a | si);
      alu_i(imm, 3'b111, a & si);
      alu_i({7'h00, sh}, 3'b001, a << sh);
      alu_i({7'h00, sh}, 3'b101, a >> sh);
      alu_i({7'h20, sh}, 3'b101, word_t'($signed(a) >>> sh));
    end
    run_program();
  endtask

  task automatic test_load_upper();
    word_t data [3];
    word_t auipc_pc;
    logic [19:0] up;
    begin_program();
    load_const(5'd10, DATA_BASE);
    load_const(5'd11, LOAD_BASE);
    for (int i = 0; i < 3; i++) begin
      data[i] = next_rand();
      image[(LOAD_BASE >> 2) + i] = data[i];
      emit(enc_i(12'(i * 4), 5'd11, 3'b010, 5'd5, 7'b0000011), 5);
      store_expect(5'd5, data[i]);
    end
    up = 20'(next_rand());
    emit({up, 5'd6, OP_LUI}, 4);
    store_expect(5'd6, {up, 12'h000});
    up = 20'(next_rand());
    // AUIPC adds to its own address
    auipc_pc = emit_pc;
    emit({up, 5'd7, OP_AUIPC}, 4);
    store_expect(5'd7, auipc_pc + {up, 12'h000});
    emit(enc_i(12'd123, 5'd11, 3'b000, 5'd0, OP_IMM), 4);
    store_expect(5'd0, 32'd0);
    run_program();
  endtask

  function automatic logic branch_taken(input logic [2:0] f3, input word_t a, input word_t b);
    case (f3)
      3'b000: return a == b;
      3'b001: return a != b;
      3'b100: return $signed(a) < $signed(b);
      3'b101: return $signed(a) >= $signed(b);
      3'b110: return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic test_branches();
    logic [2:0] conds [6];
    word_t pa [5];
    word_t pb [5];
    word_t x;
    word_t y;
    word_t n;
    word_t taken_mark;
    word_t skip_mark;
    conds = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    x = next_rand() >> 2;
    y = x + 32'd1 + (next_rand() & 32'hFF);
    n = x | 32'h8000_0000;
    pa = '{x, x, y, n, x};
    pb = '{x, y, x, x, n};
    taken_mark = 32'h7A4E_0001;
    skip_mark = 32'h40C0_0002;
    begin_program();
    load_const(5'd10, DATA_BASE);
    load_const(5'd20, taken_mark);
    load_const(5'd21, skip_mark);
    for (int p = 0; p < 5; p++) begin
      load_const(5'd1, pa[p]);
      load_const(5'd2, pb[p]);
      for (int c = 0; c < 6; c++) begin
        emit(enc_b(13'd12, 5'd2, 5'd1, conds[c]), 3);
        store_expect(5'd21, branch_taken(conds[c], pa[p], pb[p]) ? taken_mark : skip_mark);
        emit(enc_j(21'd8, 5'd0), 4);
        emit(enc_s(12'(4 * (exp_vals.size() - 1)), 5'd20, 5'd10), 4);
      end
    end
    run_program();
  endtask

  task automatic test_jumps();
    word_t p;
    word_t q;
    begin_program();
    load_const(5'd10, DATA_BASE);
    load_const(5'd22, 32'hBAD0_0001);
    p = emit_pc;
    emit(enc_j(21'd8, 5'd5), 4);
    store_forbidden(5'd22);
    store_expect(5'd5, p + 32'd4);
    q = emit_pc;
    // Odd target, the core must clear bit 0
    load_const(5'd6, q + 32'd17);
    emit(enc_i(12'd0, 5'd6, 3'b000, 5'd7, 7'b1100111), 4);
    store_forbidden(5'd22);
    store_expect(5'd7, q + 32'd12);
    run_program();
  endtask

  task automatic test_ecall_halt();
    int writes;
    begin_program();
    load_const(5'd10, DATA_BASE);
    load_const(5'd22, 32'h1234_5678);
    store_expect(5'd22, 32'h1234_5678);
    emit(32'h0000_0073, 2);
    store_forbidden(5'd22);
    run_program();
    writes = 0;
    repeat (20) begin
      @(negedge clock);
      if (mem_wr_en) begin
        writes++;
      end
    end
    check("halted", word_t'(halted), 32'd1);
    check("mem_wr_en count after halt", word_t'(writes), 32'd0);
    verify_slots();
  endtask

  initial begin
    #(WATCHDOG_NS);
    abort_run("watchdog expired, simulation took too long");
  end

  initial begin
    rst_n = 1'b0;
    load_image = 1'b0;
    rng = 32'he9ee_c78e;
    test_reset_fetch();
    test_alu();
    test_load_upper();
    test_branches();
    test_jumps();
    test_ecall_halt();
    $display("Test OK");
    $finish;
  end

endmodule

// ==== tests/tb_clock.sv ====
// ==================================================
// tb_clock
// Free-running testbench clock, 100 ns period
// ==================================================

`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD_NS = 100
) (
  output logic clock
);

  initial clock = 1'b0;

  always #(PERIOD_NS / 2) clock = ~clock;

endmodule
